//--- project.f
hdl/rv_core_pkg.sv
hdl/rv_decoder.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_pc_unit.sv
hdl/rv_core.sv
bench/rv_core_tb.sv

//--- bench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

    localparam int    RUN_CYCLES   = 2000;
    localparam int    RESET_CYCLES = 10;
    localparam xlen_t NOP          = 32'h0000_0013;   // addi x0, x0, 0

    logic      CLK;
    logic      RESET;
    xlen_t     instr_i;
    xlen_t     dmem_rdata_i;
    xlen_t     pc_o;
    dmem_req_t dmem_o;
    logic      illegal_o;

    xlen_t       prog [256];       // program words indexed by pc[9:2]
    xlen_t       mem  [512];       // data memory shared by the dut port and the model
    xlen_t       regs [32];        // model register file
    xlen_t       model_pc;
    logic [31:0] lfsr_q;
    int          checks;
    int          errors;

    rv_core #(.NUM_REGS(32)) dut0 (
        .CLK (CLK), .RESET (RESET), .instr_i (instr_i), .dmem_rdata_i (dmem_rdata_i),
        .pc_o (pc_o), .dmem_o (dmem_o), .illegal_o (illegal_o)
    );

    always #10 CLK = ~CLK;         // 20 ns period

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    // fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic xlen_t illegal_word();
        logic [1:0] pick;
        xlen_t      raw;
        xlen_t      w;
        pick = rand_bits(2);
        raw  = rand_bits(32);
        case (pick)
            2'd0:    w = {raw[31:7], 7'b1110011};                          // system opcode
            2'd1:    w = {raw[31:15], 2'b01, raw[12], raw[11:7], BRANCH};  // funct3 010 or 011
            2'd2:    w = {raw[31:15], 3'b000, raw[11:7], LOAD};            // lb
            default: w = {7'b0000001, raw[24:12], raw[11:7], OP};          // mul family
        endcase
        return w;
    endfunction

    task automatic build_program();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [19:0] upper;
        logic [7:0]  idx;
        logic        alt;
        for (int i = 0; i < 256; i++) begin
            kind  = rand_bits(4);
            rd    = rand_bits(5);
            rs1   = rand_bits(5);
            rs2   = rand_bits(5);
            f3    = rand_bits(3);
            alt   = rand_bits(1);
            imm12 = rand_bits(12);
            boff  = (rand_bits(4) + 1) * 4;          // forward only by 1 to 16 words
            joff  = (rand_bits(4) + 1) * 4;
            idx   = i + 1 + rand_bits(4);            // jalr target ahead and wrapping
            case (kind)
                4'd0: prog[i] = illegal_word();      // about one in sixteen
                4'd1, 4'd2, 4'd3: begin
                    prog[i] = {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                               rs2, rs1, f3, rd, OP};
                end
                4'd4, 4'd5, 4'd6: begin
                    if (f3 == 3'd1) imm12[11:5] = 7'h00;
                    if (f3 == 3'd5) imm12[11:5] = alt ? 7'h20 : 7'h00;   // srli or srai
                    prog[i] = {imm12, rs1, f3, rd, OP_IMM};
                end
                4'd7: begin
                    upper   = rand_bits(20);
                    prog[i] = {upper, rd, LUI};
                end
                4'd8: begin
                    upper   = rand_bits(20);
                    prog[i] = {upper, rd, AUIPC};
                end
                4'd9, 4'd10: begin
                    if (f3[2:1] == 2'b01) f3[2] = 1'b1;                   // skip reserved codes
                    prog[i] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], BRANCH};
                end
                4'd11: prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, JAL};
                4'd12: prog[i] = {2'b00, idx, 1'b0, alt, 5'd0, 3'b000, rd, JALR};  // odd imm
                4'd13, 4'd14: prog[i] = {1'b0, imm12[8:0], 2'b00, 5'd0, 3'b010, rd, LOAD};
                default: begin
                    imm12 = {1'b0, imm12[8:0], 2'b00};
                    prog[i] = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], STORE};
                end
            endcase
        end
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////
    function automatic xlen_t alu_model(input logic [2:0] f3, input logic alt,
                                        input xlen_t a, input xlen_t b);
        xlen_t r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: r = (a < b) ? 32'd1 : 32'd0;
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[4:0];                   // sign fill
                else     r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        logic t;
        case (f3)
            3'd0:    t = (a == b);
            3'd1:    t = (a != b);
            3'd4:    t = ($signed(a) < $signed(b));
            3'd5:    t = ($signed(a) >= $signed(b));
            3'd6:    t = (a < b);
            3'd7:    t = (a >= b);
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    task automatic check_value(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h (model pc %h)", name, got, exp, model_pc);
        end
    endtask

    // drive one instruction at the falling edge, check, then advance the model
    task automatic execute_step();
        xlen_t      ins, a, b, res, addr, next_pc, imm_i, imm_s, imm_b, imm_j;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [4:0] rd;
        logic       wr, is_load, is_store, bad;
        ins      = prog[model_pc[9:2]];
        f7       = ins[31:25];
        f3       = ins[14:12];
        rd       = ins[11:7];
        a        = regs[ins[19:15]];
        b        = regs[ins[24:20]];
        imm_i    = {{20{ins[31]}}, ins[31:20]};
        imm_s    = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b    = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j    = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        res      = '0;
        addr     = '0;
        next_pc  = model_pc + 32'd4;
        wr       = 1'b1;
        is_load  = 1'b0;
        is_store = 1'b0;
        bad      = 1'b0;
        case (ins[6:0])
            OP: begin
                bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
                res = alu_model(f3, f7[5], a, b);
            end
            OP_IMM: begin
                if (f3 == 3'd1) bad = (f7 != 7'h00);
                if (f3 == 3'd5) bad = (f7 != 7'h00 && f7 != 7'h20);
                res = alu_model(f3, f3 == 3'd5 && f7[5], a, imm_i);   // no subi
            end
            LUI:   res = {ins[31:12], 12'b0};
            AUIPC: res = model_pc + {ins[31:12], 12'b0};
            BRANCH: begin
                wr  = 1'b0;
                bad = (f3 == 3'd2 || f3 == 3'd3);
                if (branch_taken(f3, a, b)) next_pc = model_pc + imm_b;
            end
            JAL: begin
                res     = model_pc + 32'd4;
                next_pc = model_pc + imm_j;
            end
            JALR: begin
                bad     = (f3 != 3'd0);
                res     = model_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;                      // bit 0 cleared
            end
            LOAD: begin
                bad     = (f3 != 3'd2);
                is_load = 1'b1;
                addr    = a + imm_i;
                res     = mem[addr[10:2]];
            end
            STORE: begin
                wr       = 1'b0;
                bad      = (f3 != 3'd2);
                is_store = 1'b1;
                addr     = a + imm_s;
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            next_pc  = model_pc + 32'd4;
            wr       = 1'b0;
            is_load  = 1'b0;
            is_store = 1'b0;
        end
        instr_i      = ins;
        dmem_rdata_i = is_load ? mem[addr[10:2]] : ~model_pc;        // filler off loads
        #1;                                                          // let the decode settle
        check_value("pc_o", pc_o, model_pc);
        check_value("illegal_o", illegal_o, bad);
        check_value("dmem_o.req", dmem_o.req, is_load || is_store);
        if (is_load || is_store) begin
            check_value("dmem_o.we", dmem_o.we, is_store);
            check_value("dmem_o.addr", dmem_o.addr, addr);
        end
        if (is_store) check_value("dmem_o.wdata", dmem_o.wdata, b);
        if (wr && rd != 5'd0) regs[rd] = res;
        if (is_store) mem[addr[10:2]] = b;
        model_pc = next_pc;
    endtask

    ////////////////////////////////////////
    // run
    ////////////////////////////////////////
    initial begin
        CLK          = 1'b0;
        RESET        = 1'b1;
        instr_i      = NOP;                  // legal and without a memory request
        dmem_rdata_i = '0;
        lfsr_q       = 32'h1cc03f9f;
        checks       = 0;
        errors       = 0;
        for (int w = 0; w < 512; w++) begin
            mem[w] = (w * 4) * 32'h9e37_79b1 ^ 32'h5a5a_0f0f;   // spread over the byte address
        end
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        build_program();
        model_pc = RESET_PC;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(negedge CLK);
            check_value("pc_o", pc_o, RESET_PC);
        end
        RESET = 1'b0;                        // first instruction goes in on this edge
        for (int c = 0; c < RUN_CYCLES; c++) begin
            execute_step();
            @(negedge CLK);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog over the whole run
    initial begin
        for (int n = 0; n < RESET_CYCLES + RUN_CYCLES + 50; n++) begin
            @(posedge CLK);
        end
        $display("timeout: the run did not end within the expected number of cycles");
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; #(
    parameter int NUM_REGS = 32        // 32 for rv32i, 16 for rv32e
) (
    input  logic      CLK,
    input  logic      RESET,
    input  xlen_t     instr_i,         // instruction at pc_o, same cycle
    input  xlen_t     dmem_rdata_i,    // load data, same cycle
    output xlen_t     pc_o,
    output dmem_req_t dmem_o,
    output logic      illegal_o
);

    ctrl_t     ctrl;
    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    xlen_t     imm;
    xlen_t     rs1_data, rs2_data;
    xlen_t     op_a, op_b;
    xlen_t     alu_result;
    logic      alu_flag;
    xlen_t     wb_data;

    ////////////////////////////////////////
    // units
    ////////////////////////////////////////
    rv_decoder #(.NUM_REGS(NUM_REGS)) dec0 (
        .instr_i (instr_i),  .ctrl_o (ctrl),     .rs1_o (rs1_addr),
        .rs2_o   (rs2_addr), .rd_o   (rd_addr),  .imm_o (imm)
    );

    rv_regfile #(.NUM_REGS(NUM_REGS)) rf0 (
        .CLK   (CLK),      .RESET (RESET),
        .ra1_i (rs1_addr), .ra2_i (rs2_addr), .wa_i (rd_addr),
        .wd_i  (wb_data),  .we_i  (ctrl.rf_we),
        .rd1_o (rs1_data), .rd2_o (rs2_data)
    );

    rv_alu alu0 (
        .a_i (op_a), .b_i (op_b), .op_i (ctrl.alu_op),
        .result_o (alu_result), .flag_o (alu_flag)
    );

    rv_pc_unit pcu0 (
        .CLK (CLK), .RESET (RESET), .ctrl_i (ctrl), .flag_i (alu_flag),
        .imm_i (imm), .rs1_i (rs1_data), .pc_o (pc_o)
    );

    // operand muxes
    always_comb begin
        case (ctrl.op_a_sel)
            OP_A_RS1: op_a = rs1_data;
            OP_A_PC:  op_a = pc_o;     // auipc base and link base
            default:  op_a = '0;       // lui
        endcase
        case (ctrl.op_b_sel)
            OP_B_RS2: op_b = rs2_data;
            OP_B_IMM: op_b = imm;
            default:  op_b = 32'd4;    // link value
        endcase
    end

    assign wb_data = (ctrl.wb_sel == WB_MEM) ? dmem_rdata_i : alu_result;

    // word request, address is rs1 + imm from the alu
    assign dmem_o    = '{req: ctrl.mem_req, we: ctrl.mem_we, addr: alu_result,
                         wdata: rs2_data};
    assign illegal_o = ctrl.illegal;

    // a flagged word must never reach the memory port
    a_no_req_on_illegal: assert property (@(posedge CLK)
        !(dmem_o.req && illegal_o))
        else $error("memory request with illegal instruction %h", instr_i);

endmodule

//--- hdl/rv_pc_unit.sv
`timescale 1ns/1ps

module rv_pc_unit import rv_core_pkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    input  ctrl_t ctrl_i,
    input  logic  flag_i,              // branch condition from the alu
    input  xlen_t imm_i,               // b, j or i immediate
    input  xlen_t rs1_i,
    output xlen_t pc_o
);

    xlen_t pc_q;
    xlen_t pc_next;
    xlen_t jalr_sum;

    assign jalr_sum = rs1_i + imm_i;

    ////////////////////////////////////////
    // next pc select
    ////////////////////////////////////////
    always_comb begin
        if (ctrl_i.jalr) begin
            pc_next = {jalr_sum[31:1], 1'b0};          // bit 0 dropped
        end else if (ctrl_i.jal || (ctrl_i.branch && flag_i)) begin
            pc_next = pc_q + imm_i;                    // pc relative
        end else begin
            pc_next = pc_q + 32'd4;                    // also for illegal
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

    // targets built by the decoder and alu never break word alignment
    a_pc_aligned: assert property (@(posedge CLK) disable iff (RESET)
        pc_o[1:0] == 2'b00)
        else $error("misaligned pc %h", pc_o);

endmodule

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_core_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic      CLK,
    input  logic      RESET,
    input  reg_addr_t ra1_i,           // rs1 read port
    input  reg_addr_t ra2_i,           // rs2 read port
    input  reg_addr_t wa_i,
    input  xlen_t     wd_i,
    input  logic      we_i,
    output xlen_t     rd1_o,
    output xlen_t     rd2_o
);

    xlen_t regs [NUM_REGS];

    // x0 and missing registers read as zero
    assign rd1_o = (ra1_i == '0 || ra1_i >= NUM_REGS) ? '0 : regs[ra1_i];
    assign rd2_o = (ra2_i == '0 || ra2_i >= NUM_REGS) ? '0 : regs[ra2_i];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;         // architectural state starts at zero
            end
        end else if (we_i && wa_i != '0 && wa_i < NUM_REGS) begin
            regs[wa_i] <= wd_i;
        end
    end

    // the instruction held during reset must not target a real register
    a_no_write_in_reset: assert property (@(posedge CLK)
        RESET |-> !(we_i && wa_i != '0))
        else $error("register write to x%0d during reset", wa_i);

endmodule

//--- hdl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_core_pkg::*; (
    input  xlen_t   a_i,
    input  xlen_t   b_i,
    input  alu_op_e op_i,
    output xlen_t   result_o,          // compare ops leave the sum here
    output logic    flag_o             // branch condition
);

    xlen_t      sum;
    logic [4:0] shamt;
    logic       eq, lt_s, lt_u;

    assign sum   = a_i + b_i;
    assign shamt = b_i[4:0];           // upper bits ignored, as in rv32i
    assign eq    = (a_i == b_i);
    assign lt_s  = ($signed(a_i) < $signed(b_i));
    assign lt_u  = (a_i < b_i);

    ////////////////////////////////////////
    // result and flag
    ////////////////////////////////////////
    always_comb begin
        result_o = sum;
        flag_o   = 1'b0;
        case (op_i)
            ADD:  result_o = sum;
            SUB:  result_o = a_i - b_i;
            SLL:  result_o = a_i << shamt;
            SLT:  result_o = {31'b0, lt_s};
            SLTU: result_o = {31'b0, lt_u};
            XOR:  result_o = a_i ^ b_i;
            SRL:  result_o = a_i >> shamt;
            SRA:  result_o = $signed(a_i) >>> shamt;   // keeps the sign bit
            OR:   result_o = a_i | b_i;
            AND:  result_o = a_i & b_i;
            // branch compares
            EQ:   flag_o = eq;
            NE:   flag_o = ~eq;
            LT:   flag_o = lt_s;
            GE:   flag_o = ~lt_s;
            LTU:  flag_o = lt_u;
            GEU:  flag_o = ~lt_u;
            default: begin
                result_o = sum;
                flag_o   = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_core_pkg::*; #(
    parameter int NUM_REGS = 32        // 16 for an rv32e sized register file
) (
    input  xlen_t     instr_i,         // raw instruction word
    output ctrl_t     ctrl_o,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output reg_addr_t rd_o,
    output xlen_t     imm_o            // immediate of the current format
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    xlen_t      i_imm, s_imm, b_imm, u_imm, j_imm;
    logic       bad;                   // encoding outside the kept set
    logic       use_rs1, use_rs2, use_rd;

    assign funct7 = instr_i[31:25];
    assign funct3 = instr_i[14:12];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    ////////////////////////////////////////
    // immediate formats, all sign extended
    ////////////////////////////////////////
    assign i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
    assign s_imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign u_imm = {instr_i[31:12], 12'b0};
    assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        ctrl_o  = '0;                  // rs1 op rs2, add, no writes
        imm_o   = i_imm;
        bad     = 1'b0;
        use_rs1 = 1'b1;                // most formats read rs1
        use_rs2 = 1'b0;
        use_rd  = 1'b1;
        case (instr_i[6:0])
            OP: begin
                use_rs2      = 1'b1;
                ctrl_o.rf_we = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl_o.alu_op = ADD;
                    10'b0100000_000: ctrl_o.alu_op = SUB;
                    10'b0000000_001: ctrl_o.alu_op = SLL;
                    10'b0000000_010: ctrl_o.alu_op = SLT;
                    10'b0000000_011: ctrl_o.alu_op = SLTU;
                    10'b0000000_100: ctrl_o.alu_op = XOR;
                    10'b0000000_101: ctrl_o.alu_op = SRL;
                    10'b0100000_101: ctrl_o.alu_op = SRA;
                    10'b0000000_110: ctrl_o.alu_op = OR;
                    10'b0000000_111: ctrl_o.alu_op = AND;
                    default:         bad = 1'b1;     // funct7 out of range
                endcase
            end
            OP_IMM: begin
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.rf_we    = 1'b1;
                case (funct3)
                    3'b000: ctrl_o.alu_op = ADD;
                    3'b010: ctrl_o.alu_op = SLT;
                    3'b011: ctrl_o.alu_op = SLTU;
                    3'b100: ctrl_o.alu_op = XOR;
                    3'b110: ctrl_o.alu_op = OR;
                    3'b111: ctrl_o.alu_op = AND;
                    3'b001: begin
                        ctrl_o.alu_op = SLL;
                        bad = (funct7 != 7'b0000000);
                    end
                    default: begin             // 101, srli or srai
                        ctrl_o.alu_op = funct7[5] ? SRA : SRL;
                        bad = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            LUI, AUIPC: begin
                use_rs1         = 1'b0;
                imm_o           = u_imm;
                ctrl_o.op_a_sel = instr_i[5] ? OP_A_ZERO : OP_A_PC;   // bit 5 splits the pair
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.rf_we    = 1'b1;
            end
            BRANCH: begin
                use_rs2       = 1'b1;
                use_rd        = 1'b0;
                imm_o         = b_imm;
                ctrl_o.branch = 1'b1;
                case (funct3)
                    3'b000:  ctrl_o.alu_op = EQ;
                    3'b001:  ctrl_o.alu_op = NE;
                    3'b100:  ctrl_o.alu_op = LT;
                    3'b101:  ctrl_o.alu_op = GE;
                    3'b110:  ctrl_o.alu_op = LTU;
                    3'b111:  ctrl_o.alu_op = GEU;
                    default: bad = 1'b1;       // 010 and 011 are reserved
                endcase
            end
            JAL, JALR: begin
                // both link pc + 4, the pc unit takes the target
                use_rs1         = ~instr_i[3];
                imm_o           = instr_i[3] ? j_imm : i_imm;
                ctrl_o.op_a_sel = OP_A_PC;
                ctrl_o.op_b_sel = OP_B_FOUR;
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.jal      = instr_i[3];
                ctrl_o.jalr     = ~instr_i[3];
                bad             = ~instr_i[3] && (funct3 != 3'b000);
            end
            LOAD: begin
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.rf_we    = 1'b1;
                ctrl_o.wb_sel   = WB_MEM;
                ctrl_o.mem_req  = 1'b1;
                bad             = (funct3 != 3'b010);   // lw only
            end
            STORE: begin
                use_rs2         = 1'b1;
                use_rd          = 1'b0;
                imm_o           = s_imm;
                ctrl_o.op_b_sel = OP_B_IMM;
                ctrl_o.mem_req  = 1'b1;
                ctrl_o.mem_we   = 1'b1;
                bad             = (funct3 != 3'b010);   // sw only
            end
            default: bad = 1'b1;
        endcase
        // registers that do not exist in a reduced file
        if ((use_rs1 && rs1_o >= NUM_REGS) || (use_rs2 && rs2_o >= NUM_REGS) ||
            (use_rd && rd_o >= NUM_REGS)) begin
            bad = 1'b1;
        end
        if (bad) begin
            ctrl_o         = '0;           // no write, no branch, pc + 4
            ctrl_o.illegal = 1'b1;
        end
    end

endmodule

//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

    ////////////////////////////////////////
    // basic widths
    ////////////////////////////////////////
    typedef logic [31:0] xlen_t;       // data word and address
    typedef logic [4:0]  reg_addr_t;   // register index, x0..x31

    localparam xlen_t RESET_PC = 32'h0000_0000;   // first fetch address

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,   // register-register alu
        OP_IMM = 7'b0010011,   // register-immediate alu and shifts
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LOAD   = 7'b0000011,   // only lw is kept
        STORE  = 7'b0100011    // only sw is kept
    } opcode_e;

    // alu operations; the last six only drive the compare flag
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        EQ, NE, LT, GE, LTU, GEU
    } alu_op_e;

    ////////////////////////////////////////
    // datapath selects
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_A_RS1  = 2'd0,   // rs1 data
        OP_A_PC   = 2'd1,   // auipc, jal and jalr link
        OP_A_ZERO = 2'd2    // lui
    } op_a_sel_e;

    typedef enum logic [1:0] {
        OP_B_RS2  = 2'd0,
        OP_B_IMM  = 2'd1,   // whichever immediate the decoder picked
        OP_B_FOUR = 2'd2    // link value pc + 4
    } op_b_sel_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1       // load data straight from the port
    } wb_sel_e;

    // decoder output bundle, all zero is a harmless nop
    typedef struct packed {
        op_a_sel_e op_a_sel;
        op_b_sel_e op_b_sel;
        alu_op_e   alu_op;
        logic      rf_we;
        wb_sel_e   wb_sel;
        logic      mem_req;
        logic      mem_we;
        logic      branch;    // conditional, taken on alu flag
        logic      jal;
        logic      jalr;
        logic      illegal;
    } ctrl_t;

    // data memory request, word access only
    typedef struct packed {
        logic  req;
        logic  we;      // 1 store, 0 load
        xlen_t addr;
        xlen_t wdata;
    } dmem_req_t;

endpackage
